// File: rtl/sldu_pkg.sv
// Slide unit package
// Sizes, vector types, instruction and result beat structs, engine states

`default_nettype none

package sldu_pkg;

  // Lane and register geometry
  localparam int unsigned NrLanes   = 4;
  localparam int unsigned LaneBytes = 8;
  localparam int unsigned BeatBytes = NrLanes * LaneBytes;
  localparam int unsigned VregBytes = 128;
  localparam int unsigned VregBeats = VregBytes / BeatBytes;

  // Pointer widths derived from the geometry
  localparam int unsigned BeatPntWidth = $clog2(BeatBytes);
  localparam int unsigned VrfPntWidth  = $clog2(VregBeats);

  // Queue depths
  localparam int unsigned InsnQueueDepth   = 2;
  localparam int unsigned InsnPntWidth     = $clog2(InsnQueueDepth);
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned ResultPntWidth   = $clog2(ResultQueueDepth);

  typedef logic [8*LaneBytes-1:0] elen_t;
  typedef logic [LaneBytes-1:0]   strb_t;
  typedef logic [2:0]             vid_t;
  // Register number times VregBeats plus beat index
  typedef logic [6:0]             vaddr_t;
  typedef logic [7:0]             vlen_t;
  // Counts 0 to BeatBytes, so one bit wider than a byte index
  typedef logic [BeatPntWidth:0]  byte_pnt_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vsew_e;

  typedef enum logic {SLIDE_UP, SLIDE_DOWN} slide_op_e;

  typedef struct packed {
    vid_t       id;
    slide_op_e  op;
    vsew_e      vsew;
    vlen_t      vl;      // Element count
    vlen_t      stride;  // Elements at the sequencer, bytes once queued
    logic [4:0] vd;
  } slide_req_t;

  typedef struct packed {
    vid_t                id;
    vaddr_t              addr;
    logic                last;
    elen_t [NrLanes-1:0] wdata;
    strb_t [NrLanes-1:0] be;
  } result_beat_t;

  typedef enum logic {SLIDE_IDLE, SLIDE_RUN} slide_state_e;

endpackage

`default_nettype wire

// File: rtl/sldu_insn_queue.sv
// Slide instruction queue
// Circular store of pending slide instructions from the sequencer.
// Converts the slide amount from elements to bytes on accept and
// presents the oldest instruction to the slide engine.

`timescale 1ns/1ps
`default_nettype none

module sldu_insn_queue (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Sequencer side
  input  sldu_pkg::slide_req_t     req_i,
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  // Engine side
  output sldu_pkg::slide_req_t     insn_o,
  output logic                     insn_valid_o,
  input  wire logic                insn_done_i
);

  // Entry storage, payload only
  sldu_pkg::slide_req_t [sldu_pkg::InsnQueueDepth-1:0] entry_q;

  // Write side and read side pointers
  logic [sldu_pkg::InsnPntWidth-1:0] accept_pnt_q;
  logic [sldu_pkg::InsnPntWidth-1:0] issue_pnt_q;
  // Occupancy, one bit wider than the pointers
  logic [sldu_pkg::InsnPntWidth:0]   cnt_q;

  logic                 accept;
  logic                 pop;
  sldu_pkg::slide_req_t stored;

  // Room left as long as the queue is not full
  assign req_ready_o  = (cnt_q < sldu_pkg::InsnQueueDepth);
  assign accept       = req_valid_i && req_ready_o;

  // Oldest instruction goes to the engine
  assign insn_o       = entry_q[issue_pnt_q];
  assign insn_valid_o = (cnt_q != '0);
  assign pop          = insn_done_i && insn_valid_o;

  // Slide amount in bytes: element count shifted by the element width
  always_comb begin
    stored        = req_i;
    stored.stride = req_i.stride << req_i.vsew;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_q[accept_pnt_q] <= stored;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      cnt_q        <= '0;
    end else begin
      if (accept) begin
        // Wrap at the last entry
        if (accept_pnt_q == sldu_pkg::InsnQueueDepth - 1) accept_pnt_q <= '0;
        else accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (pop) begin
        if (issue_pnt_q == sldu_pkg::InsnQueueDepth - 1) issue_pnt_q <= '0;
        else issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      // Simultaneous accept and pop leave the count unchanged
      case ({accept, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/sldu_slide_engine.sv
// Slide engine
// Byte-copy FSM moving bytes from lane operand beats to result beats
// at the slide offset. Each step copies as many bytes as fit in both the
// current input beat and the partially built output beat.

`timescale 1ns/1ps
`default_nettype none

module sldu_slide_engine (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  // Instruction queue
  input  sldu_pkg::slide_req_t                         insn_i,
  input  wire logic                                    insn_valid_i,
  output logic                                         insn_done_o,
  // Lane operands
  input  sldu_pkg::elen_t      [sldu_pkg::NrLanes-1:0] operand_i,
  input  wire logic            [sldu_pkg::NrLanes-1:0] operand_valid_i,
  output logic                 [sldu_pkg::NrLanes-1:0] operand_ready_o,
  // Result queue
  input  wire logic                                    queue_full_i,
  output sldu_pkg::result_beat_t                       beat_o,
  output logic                                         beat_push_o
);

  sldu_pkg::slide_state_e state_q, state_d;

  // Byte pointers in the input beat and in the output beat
  sldu_pkg::byte_pnt_t in_pnt_q, in_pnt_d;
  sldu_pkg::byte_pnt_t out_pnt_q, out_pnt_d;
  // Bytes still to copy for this instruction
  sldu_pkg::vlen_t     issue_cnt_q, issue_cnt_d;
  // Beat index inside the destination register
  logic [sldu_pkg::VrfPntWidth-1:0] vrf_pnt_q, vrf_pnt_d;

  // Partially built output beat, linear byte layout
  logic [sldu_pkg::BeatBytes-1:0][7:0] buf_data_q, buf_data_d;
  logic [sldu_pkg::BeatBytes-1:0]      buf_be_q, buf_be_d;
  // Buffer merged with this step's bytes
  logic [sldu_pkg::BeatBytes-1:0][7:0] merge_data;
  logic [sldu_pkg::BeatBytes-1:0]      merge_be;

  // Operand beat seen as bytes, byte b in lane b/8 at offset b%8
  logic [sldu_pkg::BeatBytes-1:0][7:0] op_bytes;
  sldu_pkg::byte_pnt_t                 src_pnt;

  sldu_pkg::vlen_t     vl_bytes;
  sldu_pkg::byte_pnt_t in_room;
  sldu_pkg::byte_pnt_t out_room;
  sldu_pkg::byte_pnt_t step_room;
  sldu_pkg::byte_pnt_t copy_bytes;
  logic                last_step;
  logic                step_ok;

  assign op_bytes = operand_i;
  assign vl_bytes = insn_i.vl << insn_i.vsew;

  // Step size: smaller free space of the two beats, capped by what is left
  assign in_room    = sldu_pkg::byte_pnt_t'(sldu_pkg::BeatBytes) - in_pnt_q;
  assign out_room   = sldu_pkg::byte_pnt_t'(sldu_pkg::BeatBytes) - out_pnt_q;
  assign step_room  = (in_room < out_room) ? in_room : out_room;
  assign last_step  = (issue_cnt_q <= sldu_pkg::vlen_t'(step_room));
  assign copy_bytes = last_step ? sldu_pkg::byte_pnt_t'(issue_cnt_q) : step_room;

  // Full operand beat available and somewhere to put the result
  assign step_ok = (&operand_valid_i) && !queue_full_i;

  // Copy the step's byte window from the input into the output beat
  always_comb begin
    merge_data = buf_data_q;
    merge_be   = buf_be_q;
    src_pnt    = '0;
    for (int o = 0; o < sldu_pkg::BeatBytes; o++) begin
      if (sldu_pkg::byte_pnt_t'(o) >= out_pnt_q &&
          sldu_pkg::byte_pnt_t'(o) < out_pnt_q + copy_bytes) begin
        src_pnt       = sldu_pkg::byte_pnt_t'(o) - out_pnt_q + in_pnt_q;
        merge_data[o] = op_bytes[src_pnt[sldu_pkg::BeatPntWidth-1:0]];
        merge_be[o]   = 1'b1;
      end
    end
  end

  // Beat handed to the result queue
  always_comb begin
    beat_o       = '0;
    beat_o.id    = insn_i.id;
    beat_o.addr  = sldu_pkg::vaddr_t'(insn_i.vd * sldu_pkg::VregBeats + vrf_pnt_q);
    beat_o.last  = last_step;
    beat_o.wdata = merge_data;
    beat_o.be    = merge_be;
  end

  always_comb begin
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    issue_cnt_d     = issue_cnt_q;
    vrf_pnt_d       = vrf_pnt_q;
    buf_data_d      = buf_data_q;
    buf_be_d        = buf_be_q;
    insn_done_o     = 1'b0;
    operand_ready_o = '0;
    beat_push_o     = 1'b0;

    unique case (state_q)
      sldu_pkg::SLIDE_IDLE: begin
        if (insn_valid_i) begin
          state_d  = sldu_pkg::SLIDE_RUN;
          buf_be_d = '0;
          if (insn_i.op == sldu_pkg::SLIDE_UP) begin
            // Read from the start, write from the offset onwards
            in_pnt_d  = '0;
            out_pnt_d = sldu_pkg::byte_pnt_t'(insn_i.stride[sldu_pkg::BeatPntWidth-1:0]);
            vrf_pnt_d = insn_i.stride[sldu_pkg::BeatPntWidth +: sldu_pkg::VrfPntWidth];
            // Bytes below the offset are never written
            issue_cnt_d = (vl_bytes > insn_i.stride) ? vl_bytes - insn_i.stride : '0;
          end else begin
            // First operand beat already holds the offset beat
            in_pnt_d    = sldu_pkg::byte_pnt_t'(insn_i.stride[sldu_pkg::BeatPntWidth-1:0]);
            out_pnt_d   = '0;
            vrf_pnt_d   = '0;
            issue_cnt_d = vl_bytes;
          end
        end
      end
      sldu_pkg::SLIDE_RUN: begin
        if (step_ok) begin
          buf_data_d  = merge_data;
          buf_be_d    = merge_be;
          in_pnt_d    = in_pnt_q + copy_bytes;
          out_pnt_d   = out_pnt_q + copy_bytes;
          issue_cnt_d = issue_cnt_q - sldu_pkg::vlen_t'(copy_bytes);
          // Input beat used up, ask the lanes for the next one
          if (in_pnt_d == sldu_pkg::byte_pnt_t'(sldu_pkg::BeatBytes) || last_step) begin
            in_pnt_d        = '0;
            operand_ready_o = '1;
          end
          // Output beat filled, send it and start a fresh one
          if (out_pnt_d == sldu_pkg::byte_pnt_t'(sldu_pkg::BeatBytes) || last_step) begin
            out_pnt_d   = '0;
            beat_push_o = 1'b1;
            vrf_pnt_d   = vrf_pnt_q + 1'b1;
            buf_be_d    = '0;
          end
          if (last_step) begin
            state_d     = sldu_pkg::SLIDE_IDLE;
            insn_done_o = 1'b1;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    buf_data_q <= buf_data_d;
    buf_be_q   <= buf_be_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= sldu_pkg::SLIDE_IDLE;
      in_pnt_q    <= '0;
      out_pnt_q   <= '0;
      issue_cnt_q <= '0;
      vrf_pnt_q   <= '0;
    end else begin
      state_q     <= state_d;
      in_pnt_q    <= in_pnt_d;
      out_pnt_q   <= out_pnt_d;
      issue_cnt_q <= issue_cnt_d;
      vrf_pnt_q   <= vrf_pnt_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sldu_result_queue.sv
// Slide result queue
// Holds result beats until every lane has granted its write request.
// The head is popped after the last grant; a popped last beat produces
// a registered done report for the sequencer.

`timescale 1ns/1ps
`default_nettype none

module sldu_result_queue (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  // Slide engine
  input  sldu_pkg::result_beat_t                      beat_i,
  input  wire logic                                   beat_push_i,
  output logic                                        full_o,
  // Lane write ports
  output logic                [sldu_pkg::NrLanes-1:0] result_req_o,
  output sldu_pkg::vid_t      [sldu_pkg::NrLanes-1:0] result_id_o,
  output sldu_pkg::vaddr_t    [sldu_pkg::NrLanes-1:0] result_addr_o,
  output sldu_pkg::elen_t     [sldu_pkg::NrLanes-1:0] result_wdata_o,
  output sldu_pkg::strb_t     [sldu_pkg::NrLanes-1:0] result_be_o,
  input  wire logic           [sldu_pkg::NrLanes-1:0] result_gnt_i,
  // Sequencer done report
  output logic                                        done_valid_o,
  output sldu_pkg::vid_t                              done_id_o
);

  sldu_pkg::result_beat_t [sldu_pkg::ResultQueueDepth-1:0] entry_q;

  logic [sldu_pkg::ResultPntWidth-1:0] wr_pnt_q;
  logic [sldu_pkg::ResultPntWidth-1:0] rd_pnt_q;
  logic [sldu_pkg::ResultPntWidth:0]   cnt_q;
  // Lanes of the head beat still waiting for a grant
  logic [sldu_pkg::NrLanes-1:0]        pending_q;

  sldu_pkg::result_beat_t       head;
  logic                         head_valid;
  logic [sldu_pkg::NrLanes-1:0] gnt;
  logic                         pop;

  assign head       = entry_q[rd_pnt_q];
  assign head_valid = (cnt_q != '0);
  assign full_o     = (cnt_q == sldu_pkg::ResultQueueDepth);

  // Every lane sees the same beat, each with its own slice
  always_comb begin
    for (int l = 0; l < sldu_pkg::NrLanes; l++) begin
      result_req_o[l]   = head_valid && pending_q[l];
      result_id_o[l]    = head.id;
      result_addr_o[l]  = head.addr;
      result_wdata_o[l] = head.wdata[l];
      result_be_o[l]    = head.be[l];
    end
  end

  // Only grants against a live request count
  assign gnt = result_gnt_i & result_req_o;
  // Head leaves once no lane is left pending
  assign pop = head_valid && ((pending_q & ~gnt) == '0);

  always_ff @(posedge clk_i) begin
    if (beat_push_i) begin
      entry_q[wr_pnt_q] <= beat_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q     <= '0;
      rd_pnt_q     <= '0;
      cnt_q        <= '0;
      pending_q    <= '1;
      done_valid_o <= 1'b0;
      done_id_o    <= '0;
    end else begin
      if (beat_push_i) begin
        if (wr_pnt_q == sldu_pkg::ResultQueueDepth - 1) wr_pnt_q <= '0;
        else wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        if (rd_pnt_q == sldu_pkg::ResultQueueDepth - 1) rd_pnt_q <= '0;
        else rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      case ({beat_push_i, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
      // Next head starts with all lanes pending
      pending_q    <= pop ? '1 : (pending_q & ~gnt);
      done_valid_o <= pop && head.last;
      if (pop) begin
        done_id_o <= head.id;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/sldu_top.sv
// Slide unit top level
// Instruction queue feeding the slide engine, which fills the per-lane
// result queue towards the vector register file

`timescale 1ns/1ps
`default_nettype none

module sldu_top (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  // Sequencer
  input  sldu_pkg::slide_req_t                        req_i,
  input  wire logic                                   req_valid_i,
  output logic                                        req_ready_o,
  output logic                                        done_valid_o,
  output sldu_pkg::vid_t                              done_id_o,
  // Lane operands
  input  sldu_pkg::elen_t     [sldu_pkg::NrLanes-1:0] operand_i,
  input  wire logic           [sldu_pkg::NrLanes-1:0] operand_valid_i,
  output logic                [sldu_pkg::NrLanes-1:0] operand_ready_o,
  // Lane result writes
  output logic                [sldu_pkg::NrLanes-1:0] result_req_o,
  output sldu_pkg::vid_t      [sldu_pkg::NrLanes-1:0] result_id_o,
  output sldu_pkg::vaddr_t    [sldu_pkg::NrLanes-1:0] result_addr_o,
  output sldu_pkg::elen_t     [sldu_pkg::NrLanes-1:0] result_wdata_o,
  output sldu_pkg::strb_t     [sldu_pkg::NrLanes-1:0] result_be_o,
  input  wire logic           [sldu_pkg::NrLanes-1:0] result_gnt_i
);

  // Queue to engine
  sldu_pkg::slide_req_t   insn;
  logic                   insn_valid;
  logic                   insn_done;
  // Engine to result queue
  sldu_pkg::result_beat_t beat;
  logic                   beat_push;
  logic                   queue_full;

  sldu_insn_queue u_insn_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .insn_o       (insn),
    .insn_valid_o (insn_valid),
    .insn_done_i  (insn_done)
  );

  sldu_slide_engine u_slide_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn),
    .insn_valid_i    (insn_valid),
    .insn_done_o     (insn_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .queue_full_i    (queue_full),
    .beat_o          (beat),
    .beat_push_o     (beat_push)
  );

  sldu_result_queue u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .beat_i         (beat),
    .beat_push_i    (beat_push),
    .full_o         (queue_full),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .done_valid_o   (done_valid_o),
    .done_id_o      (done_id_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
// Testbench clock and reset
// 40 ns clock, active-low reset held for the first 16 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Release on a rising edge after 16 cycles
  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/sldu_props.sv
// Slide unit handshake properties
// Lane write requests hold until granted, done reports are single
// pulses per instruction, and a full instruction queue refuses requests

`timescale 1ns/1ps
`default_nettype none

module sldu_props (
  input wire logic                                  clk_i,
  input wire logic                                  rst_ni,
  input wire logic                                  req_valid_i,
  input wire logic                                  req_ready_i,
  input wire logic                                  insn_done_i,
  input wire logic                                  done_valid_i,
  input sldu_pkg::vid_t                             done_id_i,
  input wire logic        [sldu_pkg::NrLanes-1:0]   result_req_i,
  input wire logic        [sldu_pkg::NrLanes-1:0]   result_gnt_i,
  input sldu_pkg::vaddr_t [sldu_pkg::NrLanes-1:0]   result_addr_i,
  input sldu_pkg::elen_t  [sldu_pkg::NrLanes-1:0]   result_wdata_i,
  input sldu_pkg::strb_t  [sldu_pkg::NrLanes-1:0]   result_be_i
);

  // Instructions held in the unit, from sequencer accepts and engine completions
  logic [sldu_pkg::InsnPntWidth:0] held_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= '0;
    end else begin
      case ({req_valid_i && req_ready_i, insn_done_i})
        2'b10:   held_q <= held_q + 1'b1;
        2'b01:   held_q <= held_q - 1'b1;
        default: held_q <= held_q;
      endcase
    end
  end

  // Ungranted request keeps its payload
  for (genvar l = 0; l < sldu_pkg::NrLanes; l++) begin : g_lane
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_i[l] && !result_gnt_i[l] |=> result_req_i[l] &&
        $stable(result_addr_i[l]) && $stable(result_wdata_i[l]) && $stable(result_be_i[l]))
      else $error("Lane %0d write request changed before its grant", l);
  end

  // Back to back reports only for different instructions
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_i |=> !done_valid_i || (done_id_i != $past(done_id_i)))
    else $error("done_valid_o held for the same id");

  // No room for a third instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (held_q == sldu_pkg::InsnQueueDepth) |-> !req_ready_i)
    else $error("req_ready_o high with two instructions held");

endmodule

bind sldu_top sldu_props u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_valid_i    (req_valid_i),
  .req_ready_i    (req_ready_o),
  .insn_done_i    (insn_done),
  .done_valid_i   (done_valid_o),
  .done_id_i      (done_id_o),
  .result_req_i   (result_req_o),
  .result_gnt_i   (result_gnt_i),
  .result_addr_i  (result_addr_o),
  .result_wdata_i (result_wdata_o),
  .result_be_i    (result_be_o)
);

`default_nettype wire

// File: sim/sldu_tb.sv
// Slide unit testbench
// Reads slide instructions from the stim file, serves lane operands,
// grants lane writes with stalls and checks every written beat and the
// done reports against a byte-level model of the slide

`timescale 1ns/1ps
`default_nettype none

module sldu_tb;

  logic clk;
  logic rst_n;

  sldu_pkg::slide_req_t                        req;
  logic                                        req_valid;
  logic                                        req_ready;
  logic                                        done_valid;
  sldu_pkg::vid_t                              done_id;
  sldu_pkg::elen_t    [sldu_pkg::NrLanes-1:0]  operand;
  logic               [sldu_pkg::NrLanes-1:0]  operand_valid;
  logic               [sldu_pkg::NrLanes-1:0]  operand_ready;
  logic               [sldu_pkg::NrLanes-1:0]  result_req;
  sldu_pkg::vid_t     [sldu_pkg::NrLanes-1:0]  result_id;
  sldu_pkg::vaddr_t   [sldu_pkg::NrLanes-1:0]  result_addr;
  sldu_pkg::elen_t    [sldu_pkg::NrLanes-1:0]  result_wdata;
  sldu_pkg::strb_t    [sldu_pkg::NrLanes-1:0]  result_be;
  logic               [sldu_pkg::NrLanes-1:0]  result_gnt;

  // Instructions in stim order and their per-instruction data
  sldu_pkg::slide_req_t insn_list[$];
  logic [7:0]           base_list[$];
  logic [7:0]           stall_list[$];
  int                   beats_list[$];
  int                   op_beats[$];
  int                   src_start[$];
  int                   beat_start[$];
  // Expected beats of all instructions, in delivery order
  logic [sldu_pkg::BeatBytes-1:0][7:0] exp_data[$];
  logic [sldu_pkg::BeatBytes-1:0]      exp_be[$];
  sldu_pkg::vaddr_t                    exp_addr[$];
  sldu_pkg::vid_t                      exp_id[$];
  int                                  exp_insn[$];

  int     err_cnt = 0;
  int     done_cnt = 0;
  int     cycle = 0;
  int     serve_idx = 0;
  int     serve_cnt = 0;
  int     lane_beat [sldu_pkg::NrLanes];
  logic   saw_full = 1'b0;
  integer seed;

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  sldu_top dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .done_valid_o    (done_valid),
    .done_id_o       (done_id),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_req_o    (result_req),
    .result_id_o     (result_id),
    .result_addr_o   (result_addr),
    .result_wdata_o  (result_wdata),
    .result_be_o     (result_be),
    .result_gnt_i    (result_gnt)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  function automatic logic [63:0] byte_mask(input sldu_pkg::strb_t be);
    logic [63:0] m;
    for (int o = 0; o < sldu_pkg::LaneBytes; o++) m[o*8 +: 8] = {8{be[o]}};
    return m;
  endfunction

  // Source register byte p holds base plus p
  function automatic logic [sldu_pkg::BeatBytes-1:0][7:0] source_beat(input logic [7:0] base,
                                                                     input int beat);
    logic [sldu_pkg::BeatBytes-1:0][7:0] bytes;
    for (int b = 0; b < sldu_pkg::BeatBytes; b++) begin
      bytes[b] = 8'(base + beat * sldu_pkg::BeatBytes + b);
    end
    return bytes;
  endfunction

  // Parse the stim file and build the expected beats of each slide
  task automatic load_stim();
    int fd;
    string line;
    int id, op, ew, vl, stride, vd, base, stall, beats;
    int vlb, sb, first, last, j, b, k;
    sldu_pkg::slide_req_t r;
    logic [sldu_pkg::BeatBytes-1:0][7:0] data;
    logic [sldu_pkg::BeatBytes-1:0]      be;
    fd = $fopen("sim/sldu_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file sim/sldu_stim.txt");
      err_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      // Comment and blank lines do not give nine fields
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  id, op, ew, vl, stride, vd, base, stall, beats) != 9) continue;
      r        = '0;
      r.id     = sldu_pkg::vid_t'(id);
      r.op     = sldu_pkg::slide_op_e'(op);
      r.vsew   = sldu_pkg::vsew_e'(ew);
      r.vl     = 8'(vl);
      r.stride = 8'(stride);
      r.vd     = 5'(vd);
      insn_list.push_back(r);
      base_list.push_back(8'(base));
      stall_list.push_back(8'(stall));
      beats_list.push_back(beats);
      // Element counts to bytes
      vlb   = (vl << ew) & 8'hff;
      sb    = (stride << ew) & 8'hff;
      first = (op == 0) ? sb / sldu_pkg::BeatBytes : 0;
      last  = (vlb - 1) / sldu_pkg::BeatBytes;
      beat_start.push_back(exp_data.size());
      src_start.push_back((op == 0) ? 0 : sb / sldu_pkg::BeatBytes);
      // Source beats touched by the copy
      op_beats.push_back((op == 0) ? (vlb - sb + 31) / 32 : (sb % 32 + vlb + 31) / 32);
      for (j = first; j <= last; j++) begin
        data = '0;
        be   = '0;
        for (b = 0; b < sldu_pkg::BeatBytes; b++) begin
          k = j * sldu_pkg::BeatBytes + b;
          if (op == 0 && k >= sb && k < vlb) begin
            be[b]   = 1'b1;
            data[b] = 8'(base + k - sb);
          end else if (op != 0 && k < vlb) begin
            be[b]   = 1'b1;
            data[b] = 8'(base + k + sb);
          end
        end
        exp_data.push_back(data);
        exp_be.push_back(be);
        exp_addr.push_back(sldu_pkg::vaddr_t'(vd * sldu_pkg::VregBeats + j));
        exp_id.push_back(sldu_pkg::vid_t'(id));
        exp_insn.push_back(insn_list.size() - 1);
      end
    end
    $fclose(fd);
  endtask

  // One granted lane write against the next expected beat of that lane
  task automatic check_write(input int l);
    int g;
    logic [63:0] mask;
    g = lane_beat[l];
    if (g >= exp_data.size()) begin
      $display("Lane %0d wrote a beat after all expected beats", l);
      err_cnt++;
    end else begin
      mask = byte_mask(exp_be[g][l*8 +: 8]);
      check_value($sformatf("result_be_o[%0d]", l), result_be[l], exp_be[g][l*8 +: 8]);
      check_value($sformatf("result_addr_o[%0d]", l), result_addr[l], exp_addr[g]);
      check_value($sformatf("result_id_o[%0d]", l), result_id[l], exp_id[g]);
      check_value($sformatf("result_wdata_o[%0d]", l), result_wdata[l] & mask,
                  exp_data[g][l*8 +: 8] & mask);
    end
    lane_beat[l]++;
  endtask

  // Done must follow all beats of the oldest open instruction
  task automatic check_done();
    int i;
    i = done_cnt;
    if (i >= insn_list.size()) begin
      $display("Done report for id %0h with no instruction left", done_id);
      err_cnt++;
    end else begin
      check_value("done_id_o", done_id, insn_list[i].id);
      for (int l = 0; l < sldu_pkg::NrLanes; l++) begin
        check_value($sformatf("beats before done_valid_o, lane %0d", l),
                    lane_beat[l] - beat_start[i], beats_list[i]);
      end
    end
    done_cnt++;
  endtask

  // Lane side: checks, operand serving and grants on each rising edge
  always @(posedge clk) begin : lane_model
    int g;
    int cur;
    logic [7:0] stall;
    if (rst_n) begin
      cycle++;
      // Done before grants, the next head's grants come no earlier
      if (done_valid) check_done();
      for (int l = 0; l < sldu_pkg::NrLanes; l++) begin
        if (result_req[l] && result_gnt[l]) check_write(l);
      end
      if (operand_ready != '0) begin
        if (serve_idx >= insn_list.size()) begin
          $display("Operand ready with no instruction left to serve");
          err_cnt++;
        end else begin
          serve_cnt++;
          if (serve_cnt == op_beats[serve_idx]) begin
            serve_idx++;
            serve_cnt = 0;
          end
        end
      end
      if (serve_idx < insn_list.size()) begin
        operand       <= source_beat(base_list[serve_idx], src_start[serve_idx] + serve_cnt);
        operand_valid <= '1;
      end else begin
        operand_valid <= '0;
      end
      // Stall pattern of the instruction each lane is writing, skewed per lane
      for (int l = 0; l < sldu_pkg::NrLanes; l++) begin
        g     = lane_beat[l];
        cur   = (g < exp_insn.size()) ? exp_insn[g] : 0;
        stall = (cur < stall_list.size()) ? stall_list[cur] : 8'h00;
        result_gnt[l] <= !stall[(cycle + l) % 8] && (($random(seed) & 7) != 0);
      end
    end
  end

  // Sequencer side: reset checks, then every instruction as fast as accepted
  initial begin : drive_requests
    int i;
    seed          = 32'ha83c;
    req           = '0;
    req_valid     = 1'b0;
    operand       = '0;
    operand_valid = '0;
    result_gnt    = '0;
    for (i = 0; i < sldu_pkg::NrLanes; i++) lane_beat[i] = 0;
    load_stim();
    @(posedge rst_n);
    @(posedge clk);
    check_value("result_req_o", result_req, '0);
    check_value("operand_ready_o", operand_ready, '0);
    check_value("done_valid_o", done_valid, 1'b0);
    check_value("req_ready_o", req_ready, 1'b1);
    for (i = 0; i < insn_list.size(); i++) begin
      req       <= insn_list[i];
      req_valid <= 1'b1;
      @(posedge clk);
      while (!req_ready) begin
        saw_full = 1'b1;
        @(posedge clk);
      end
    end
    req_valid <= 1'b0;
  end

  initial begin : run_control
    int limit;
    @(posedge rst_n);
    limit = 64 * insn_list.size() + 200;
    while (done_cnt < insn_list.size() && cycle < limit) @(negedge clk);
    if (done_cnt < insn_list.size()) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions done",
               cycle, done_cnt, insn_list.size());
      err_cnt++;
    end else begin
      // Room for late or repeated writes to show up
      repeat (8) @(negedge clk);
      for (int l = 0; l < sldu_pkg::NrLanes; l++) begin
        check_value($sformatf("beats written on lane %0d", l), lane_beat[l], exp_data.size());
      end
      check_value("done reports", done_cnt, insn_list.size());
      check_value("operand instructions served", serve_idx, insn_list.size());
      if (!saw_full) begin
        $display("req_ready_o never dropped while instructions were queued");
        err_cnt++;
      end
    end
    $display("Checks failed: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rtl/sldu_pkg.sv
rtl/sldu_insn_queue.sv
rtl/sldu_slide_engine.sv
rtl/sldu_result_queue.sv
rtl/sldu_top.sv
sim/tb_clock.sv
sim/sldu_props.sv
sim/sldu_tb.sv

// File: Makefile
# Verilator build and run of the slide unit testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= sldu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/sldu_stim.txt
// id op vsew vl stride vd base stall beats, all hex, stride in elements
// op 0 up 1 down, vsew 0..3 for 8..64 bit, stall bit n blocks grants in cycle n mod 8
1 0 0 40 05 02 10 00 2
2 1 0 30 03 03 a0 00 2
3 0 1 20 12 04 33 00 1
4 1 2 10 0b 05 5c 00 2
5 0 3 10 03 06 e0 aa 4
6 1 0 80 00 07 01 ee 4
7 1 1 2d 07 08 77 5a 3
0 0 0 7f 41 09 c8 0f 2
1 0 2 08 01 1f fe 00 1
2 1 3 02 05 0a 42 f0 1
